// File: vlog.f
source/ddr_pkg.sv
source/ddr_init_seq.sv
source/ddr_refresh_timer.sv
source/ddr_apb_regs.sv
source/ddr_cmd_arbiter.sv
source/ddr_cmd_front.sv
sim/tb_ddr_cmd_front.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the DDR command front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_ddr_cmd_front \
	-f vlog.f -o tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/tb_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "Result: PASSED"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: sim/tb_ddr_cmd_front.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ddr_cmd_front
	import ddr_pkg::*;
();

	localparam logic [15:0] init_wait_cycles   = 16'd20;
	localparam logic [7:0]  step_cycles        = 8'd4;
	localparam logic [15:0] ref_interval_reset = 16'd50;
	localparam int reset_cycles    = 4;
	localparam int max_interval    = 60;
	localparam int wait_limit      = 4 * (max_interval + 2);
	localparam int watchdog_cycles = reset_cycles + init_wait_cycles + 10 * step_cycles +
		8 * (ref_interval_reset + 2) + 6 * (max_interval + 2) + 200;

	typedef struct packed {
		logic [31:0] cyc;
		ddr_cmd_e    cmd;
		logic [1:0]  ba;
		logic [12:0] a;
	} bus_entry_t;

	logic        clk = 1'b0;
	logic        reset;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        initializing;
	logic        cke;
	logic        cs_n;
	logic        ras_n;
	logic        cas_n;
	logic        we_n;
	logic [1:0]  ba;
	logic [12:0] a;

	int          cyc = 0;
	int          rel_cyc;
	int          cke_cyc;
	int          init_fall_cyc;
	int          done_cyc;
	bit          init_done = 1'b0;
	logic [31:0] rd_data;
	logic        rd_err;
	logic        rd_init;
	int unsigned seed_val;
	ddr_cmd_e    seen_cmd;
	bus_entry_t  entry;
	bus_entry_t  bus_q[$];
	int          ref_stamps[$];

	ddr_cmd_front #(
		.init_wait_cycles   (init_wait_cycles),
		.step_cycles        (step_cycles),
		.ref_interval_reset (ref_interval_reset),
		.ba_width           (2),
		.a_width            (13)
	) DUT (
		.clk          (clk),
		.reset        (reset),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.initializing (initializing),
		.cke          (cke),
		.cs_n         (cs_n),
		.ras_n        (ras_n),
		.cas_n        (cas_n),
		.we_n         (we_n),
		.ba           (ba),
		.a            (a)
	);

	initial begin
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// --------------------
	// reporting
	// --------------------
	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "stopping after the first error");
	endtask

	task automatic check_equal(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			stop_with_error($sformatf("** Error: %s is 0x%0h, expected 0x%0h",
				name, actual, expected));
		end
	endtask

	// --------------------
	// bus monitor
	// --------------------
	// pins sampled mid-cycle, stamp is the cycle they were driven in
	always @(negedge clk) begin
		if (!reset) begin
			if (!initializing && !init_done) begin
				init_done = 1'b1;
				init_fall_cyc = cyc;
			end
			if (cs_n) begin
				stop_with_error("cs_n went high on the command bus");
			end
			seen_cmd = cmd_nop;
			case ({ras_n, cas_n, we_n})
				3'b111: seen_cmd = cmd_nop;
				3'b010: seen_cmd = cmd_pall;
				3'b000: seen_cmd = cmd_mrs;
				3'b001: seen_cmd = cmd_ref;
				default: stop_with_error("undefined ras_n cas_n we_n pattern on the bus");
			endcase
			if (seen_cmd != cmd_nop) begin
				entry.cyc = cyc;
				entry.cmd = seen_cmd;
				entry.ba  = ba;
				entry.a   = a;
				bus_q.push_back(entry);
				// only refreshes after init count toward status
				if (seen_cmd == cmd_ref && !initializing) begin
					ref_stamps.push_back(cyc);
				end
			end
		end
	end

	// --------------------
	// APB driver
	// --------------------
	task automatic wait_ready();
		int n;
		n = 0;
		@(negedge clk);
		while (!pready) begin
			n++;
			if (n > 1000) begin
				stop_with_error("APB access never completed, pready stayed low");
			end
			@(negedge clk);
		end
		done_cyc = cyc;
		rd_data  = prdata;
		rd_err   = pslverr;
		rd_init  = initializing;
	endtask

	task automatic apb_access(input logic write, input logic [7:0] addr,
		input logic [31:0] data);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= write;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge clk);
		penable <= 1'b1;
		wait_ready();
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		apb_access(1'b1, addr, data);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		apb_access(1'b0, addr, 32'd0);
		data = rd_data;
	endtask

	// --------------------
	// helpers
	// --------------------
	// power-up order: pall, emrs, mrs, pall, ref, ref, mrs
	function automatic ddr_cmd_e init_cmd_at(input int i);
		case (i)
			0, 3: return cmd_pall;
			4, 5: return cmd_ref;
			default: return cmd_mrs;
		endcase
	endfunction

	task automatic check_bus_nop();
		check_equal("cke", cke, 1'b0);
		check_equal("cs_n", cs_n, 1'b0);
		check_equal("ras_n", ras_n, 1'b1);
		check_equal("cas_n", cas_n, 1'b1);
		check_equal("we_n", we_n, 1'b1);
		check_equal("ba", ba, 2'b00);
		check_equal("a", a, 13'd0);
	endtask

	task automatic wait_refreshes(input int target);
		int n;
		n = 0;
		while (ref_stamps.size() < target) begin
			@(posedge clk);
			n++;
			if (n > wait_limit) begin
				stop_with_error("no refresh command appeared in time");
			end
		end
	endtask

	// interval, grant cycle and one cycle of pin latency
	task automatic check_refresh_period(input int interval);
		int base;
		base = ref_stamps.size();
		wait_refreshes(base + 3);
		check_equal("refresh period", ref_stamps[base + 1] - ref_stamps[base], interval + 2);
		check_equal("refresh period", ref_stamps[base + 2] - ref_stamps[base + 1], interval + 2);
	endtask

	// --------------------
	// tests
	// --------------------
	task automatic test_reset_and_cke();
		int n;
		repeat (reset_cycles - 1) @(posedge clk);
		@(negedge clk);
		check_bus_nop();
		check_equal("initializing", initializing, 1'b1);
		@(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		rel_cyc = cyc;
		check_bus_nop();
		n = 0;
		while (!cke) begin
			@(negedge clk);
			n++;
			if (n > wait_limit) begin
				stop_with_error("cke never rose after reset release");
			end
		end
		cke_cyc = cyc;
		check_equal("cke rise delay", cke_cyc - rel_cyc, init_wait_cycles + 1);
	endtask

	task automatic test_init_with_manual();
		logic [1:0]     wr_ba;
		logic [12:0]    wr_a;
		ddr_mode_word_u mw;
		int             i;
		wr_ba = 2'($urandom);
		wr_a  = 13'($urandom);
		// manual precharge requested while init still runs
		apb_write(reg_manual_cmd, {14'd0, wr_a, wr_ba, cmd_pall});
		@(posedge clk);
		check_equal("initializing at pready", rd_init, 1'b0);
		check_equal("manual grant cycle", done_cyc, init_fall_cyc);
		check_equal("commands seen", bus_q.size() >= 8, 1'b1);
		check_equal("first init command delay", bus_q[0].cyc - cke_cyc, step_cycles + 1);
		for (i = 0; i < 7; i++) begin
			check_equal("init command", bus_q[i].cmd, init_cmd_at(i));
			check_equal("init bank", bus_q[i].ba, (i == 1) ? 2'b01 : 2'b00);
			if (i > 0) begin
				check_equal("init spacing", bus_q[i].cyc - bus_q[i - 1].cyc, step_cycles);
			end
		end
		check_equal("precharge a10", bus_q[0].a[10], 1'b1);
		check_equal("precharge a10", bus_q[3].a[10], 1'b1);
		mw = bus_q[1].a;
		check_equal("emrs dll_disable", mw.emrs.dll_disable, 1'b0);
		check_equal("emrs drive_strength", mw.emrs.drive_strength,
			emrs_init.emrs.drive_strength);
		mw = bus_q[2].a;
		check_equal("mrs dll_reset", mw.mrs.dll_reset, 1'b1);
		check_equal("mrs cas_latency", mw.mrs.cas_latency, mrs_init_dll_reset.mrs.cas_latency);
		mw = bus_q[6].a;
		check_equal("mrs dll_reset", mw.mrs.dll_reset, 1'b0);
		check_equal("mrs burst_len", mw.mrs.burst_len, mrs_init_normal.mrs.burst_len);
		check_equal("initializing fall", init_fall_cyc, bus_q[6].cyc - 1 + step_cycles);
		check_equal("manual command", bus_q[7].cmd, cmd_pall);
		check_equal("manual command cycle", bus_q[7].cyc, init_fall_cyc + 1);
		check_equal("manual bank", bus_q[7].ba, wr_ba);
		check_equal("manual address", bus_q[7].a, wr_a | 13'h400);
	endtask

	task automatic test_default_refresh();
		check_refresh_period(ref_interval_reset);
		check_equal("first refresh delay", ref_stamps[0] - init_fall_cyc, ref_interval_reset + 2);
	endtask

	task automatic test_new_interval();
		logic [15:0] interval;
		logic [31:0] rdata;
		interval = 16'($urandom_range(max_interval, 20));
		apb_write(reg_ref_interval, {16'd0, interval});
		apb_read(reg_ref_interval, rdata);
		check_equal("reg_ref_interval", rdata, {16'd0, interval});
		check_refresh_period(interval);
	endtask

	task automatic test_manual_cmd(input ddr_cmd_e cmd);
		logic [1:0]  wr_ba;
		logic [12:0] wr_a;
		logic [31:0] data;
		logic [31:0] rdata;
		int          start;
		int          hits;
		int          idx;
		wr_ba = 2'($urandom);
		wr_a  = 13'($urandom);
		data  = {14'd0, wr_a, wr_ba, cmd};
		start = cyc;
		apb_write(reg_manual_cmd, data);
		@(posedge clk);
		hits = 0;
		idx  = -1;
		foreach (bus_q[i]) begin
			if (bus_q[i].cyc > start && bus_q[i].cmd == cmd) begin
				hits++;
			end
			if (bus_q[i].cyc == done_cyc + 1) begin
				idx = i;
			end
		end
		// timer refreshes share the code, so count only the others
		if (cmd != cmd_ref) begin
			check_equal("manual command count", hits, 1);
		end
		check_equal("manual command on bus", idx >= 0, 1'b1);
		check_equal("manual command", bus_q[idx].cmd, cmd);
		check_equal("manual bank", bus_q[idx].ba, wr_ba);
		check_equal("manual address", bus_q[idx].a,
			(cmd == cmd_pall) ? (wr_a | 13'h400) : wr_a);
		apb_read(reg_manual_cmd, rdata);
		check_equal("reg_manual_cmd", rdata, data);
	endtask

	task automatic test_status_and_errors();
		logic [31:0] rdata;
		wait_refreshes(ref_stamps.size() + 1);
		apb_read(reg_status, rdata);
		check_equal("pslverr", rd_err, 1'b0);
		check_equal("status refresh count", rdata[31:16], ref_stamps.size());
		check_equal("status initializing", rdata[0], 1'b0);
		apb_read(8'h0c, rdata);
		check_equal("pslverr on unknown offset", rd_err, 1'b1);
	endtask

	// --------------------
	// main sequence
	// --------------------
	initial begin
		seed_val = $urandom(20);
		reset    = 1'b1;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = 8'd0;
		pwdata   = 32'd0;
		test_reset_and_cke();
		test_init_with_manual();
		test_default_refresh();
		test_new_interval();
		test_manual_cmd(cmd_pall);
		test_manual_cmd(cmd_mrs);
		test_manual_cmd(cmd_ref);
		test_status_and_errors();
		$display("Result: PASSED");
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		stop_with_error("watchdog timeout, the tests did not finish in time");
	end

endmodule

`default_nettype wire

// File: source/ddr_cmd_front.sv
`timescale 1ns/1ps
`default_nettype none

module ddr_cmd_front
	import ddr_pkg::*;
#(
	parameter logic [15:0] init_wait_cycles   = 16'd20000,
	parameter logic [7:0]  step_cycles        = 8'd40,
	parameter logic [15:0] ref_interval_reset = 16'd780,
	parameter int          ba_width           = 2,
	parameter int          a_width            = 13
) (
	input  wire                 clk,
	input  wire                 reset,
	input  wire                 psel,
	input  wire                 penable,
	input  wire                 pwrite,
	input  wire  [7:0]          paddr,
	input  wire  [31:0]         pwdata,
	output logic [31:0]         prdata,
	output logic                pready,
	output logic                pslverr,
	output logic                initializing,
	output logic                cke,
	output logic                cs_n,
	output logic                ras_n,
	output logic                cas_n,
	output logic                we_n,
	output logic [ba_width-1:0] ba,
	output logic [a_width-1:0]  a
);

	// --------------------
	// internal wiring
	// --------------------
	logic                init_valid;
	ddr_cmd_e            init_cmd;
	logic [ba_width-1:0] init_ba;
	logic [a_width-1:0]  init_a;
	logic                man_req;
	ddr_cmd_e            man_cmd;
	logic [1:0]          man_ba;
	logic [12:0]         man_a;
	logic                man_gnt;
	logic                ref_req;
	logic                ref_gnt;
	logic                ref_issued;
	logic [15:0]         ref_interval;

	ddr_init_seq #(
		.init_wait_cycles (init_wait_cycles),
		.step_cycles      (step_cycles),
		.ba_width         (ba_width),
		.a_width          (a_width)
	) u_init_seq (
		.clk          (clk),
		.reset        (reset),
		.cke          (cke),
		.initializing (initializing),
		.init_valid   (init_valid),
		.init_cmd     (init_cmd),
		.init_ba      (init_ba),
		.init_a       (init_a)
	);

	ddr_refresh_timer u_refresh_timer (
		.clk          (clk),
		.reset        (reset),
		.initializing (initializing),
		.ref_interval (ref_interval),
		.ref_gnt      (ref_gnt),
		.ref_req      (ref_req)
	);

	ddr_apb_regs #(
		.ref_interval_reset (ref_interval_reset)
	) u_apb_regs (
		.clk          (clk),
		.reset        (reset),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.initializing (initializing),
		.man_gnt      (man_gnt),
		.ref_issued   (ref_issued),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.ref_interval (ref_interval),
		.man_req      (man_req),
		.man_cmd      (man_cmd),
		.man_ba       (man_ba),
		.man_a        (man_a)
	);

	// init first, then manual, then refresh
	ddr_cmd_arbiter #(
		.ba_width (ba_width),
		.a_width  (a_width)
	) u_cmd_arbiter (
		.clk          (clk),
		.reset        (reset),
		.init_valid   (init_valid),
		.init_cmd     (init_cmd),
		.init_ba      (init_ba),
		.init_a       (init_a),
		.man_req      (man_req),
		.man_cmd      (man_cmd),
		.man_ba       (man_ba),
		.man_a        (man_a),
		.ref_req      (ref_req),
		.initializing (initializing),
		.man_gnt      (man_gnt),
		.ref_gnt      (ref_gnt),
		.ref_issued   (ref_issued),
		.cs_n         (cs_n),
		.ras_n        (ras_n),
		.cas_n        (cas_n),
		.we_n         (we_n),
		.ba           (ba),
		.a            (a)
	);

endmodule

`default_nettype wire

// File: source/ddr_cmd_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module ddr_cmd_arbiter
	import ddr_pkg::*;
#(
	parameter int ba_width = 2,
	parameter int a_width  = 13
) (
	input  wire                 clk,
	input  wire                 reset,
	input  wire                 init_valid,
	input  wire ddr_cmd_e       init_cmd,
	input  wire [ba_width-1:0]  init_ba,
	input  wire [a_width-1:0]   init_a,
	input  wire                 man_req,
	input  wire ddr_cmd_e       man_cmd,
	input  wire [ba_width-1:0]  man_ba,
	input  wire [a_width-1:0]   man_a,
	input  wire                 ref_req,
	input  wire                 initializing,
	output logic                man_gnt,
	output logic                ref_gnt,
	output logic                ref_issued,
	output logic                cs_n,
	output logic                ras_n,
	output logic                cas_n,
	output logic                we_n,
	output logic [ba_width-1:0] ba,
	output logic [a_width-1:0]  a
);

	logic                blocked;
	ddr_cmd_e            sel_cmd;
	logic [ba_width-1:0] sel_ba;
	logic [a_width-1:0]  sel_a;
	logic                next_cs_n;
	logic                next_ras_n;
	logic                next_cas_n;
	logic                next_we_n;
	logic [ba_width-1:0] next_ba;
	logic [a_width-1:0]  next_a;

	// --------------------
	// priority select
	// --------------------
	assign blocked = initializing | init_valid;
	assign man_gnt = man_req & ~blocked;
	assign ref_gnt = ref_req & ~man_req & ~blocked;

	always_comb begin
		sel_cmd = cmd_nop;
		sel_ba  = '0;
		sel_a   = '0;
		if (init_valid) begin
			sel_cmd = init_cmd;
			sel_ba  = init_ba;
			sel_a   = init_a;
		end else if (man_gnt) begin
			sel_cmd = man_cmd;
			sel_ba  = man_ba;
			sel_a   = man_a;
		end else if (ref_gnt) begin
			sel_cmd = cmd_ref;
		end
	end

	// --------------------
	// pin encoding
	// --------------------
	always_comb begin
		next_cs_n  = 1'b0;
		next_ras_n = 1'b1;
		next_cas_n = 1'b1;
		next_we_n  = 1'b1;
		next_ba    = sel_ba;
		next_a     = sel_a;
		case (sel_cmd)
			cmd_nop: begin
				next_ba = '0;
				next_a  = '0;
			end
			cmd_pall: begin
				next_ras_n = 1'b0;
				next_we_n  = 1'b0;
				// all banks
				next_a[10] = 1'b1;
			end
			cmd_mrs: begin
				next_ras_n = 1'b0;
				next_cas_n = 1'b0;
				next_we_n  = 1'b0;
			end
			cmd_ref: begin
				next_ras_n = 1'b0;
				next_cas_n = 1'b0;
			end
			default: begin
				// undefined manual code, deselect the device
				next_cs_n = 1'b1;
				next_ba   = '0;
				next_a    = '0;
			end
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cs_n       <= 1'b0;
			ras_n      <= 1'b1;
			cas_n      <= 1'b1;
			we_n       <= 1'b1;
			ba         <= '0;
			a          <= '0;
			ref_issued <= 1'b0;
		end else begin
			cs_n       <= next_cs_n;
			ras_n      <= next_ras_n;
			cas_n      <= next_cas_n;
			we_n       <= next_we_n;
			ba         <= next_ba;
			a          <= next_a;
			// init refreshes are not counted
			ref_issued <= ref_gnt | (man_gnt & (man_cmd == cmd_ref));
		end
	end

endmodule

`default_nettype wire

// File: source/ddr_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ddr_apb_regs
	import ddr_pkg::*;
#(
	parameter logic [15:0] ref_interval_reset = 16'd780
) (
	input  wire         clk,
	input  wire         reset,
	input  wire         psel,
	input  wire         penable,
	input  wire         pwrite,
	input  wire  [7:0]  paddr,
	input  wire  [31:0] pwdata,
	input  wire         initializing,
	input  wire         man_gnt,
	input  wire         ref_issued,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	output logic [15:0] ref_interval,
	output logic        man_req,
	output ddr_cmd_e    man_cmd,
	output logic [1:0]  man_ba,
	output logic [12:0] man_a
);

	logic        access;
	logic        known_addr;
	logic        man_write;
	logic        man_setup;
	logic [15:0] ref_count;

	// --------------------
	// decode
	// --------------------
	assign access     = psel & penable;
	assign known_addr = (paddr == reg_status) | (paddr == reg_ref_interval) |
		(paddr == reg_manual_cmd);
	assign man_write  = pwrite & (paddr == reg_manual_cmd);
	// command is latched in the setup phase
	assign man_setup  = psel & ~penable & man_write;

	// manual write waits for its grant, all else is immediate
	assign pready  = access & (~man_write | man_gnt);
	assign pslverr = access & ~known_addr;

	always_comb begin
		case (paddr)
			reg_status:       prdata = {ref_count, 15'd0, initializing};
			reg_ref_interval: prdata = {16'd0, ref_interval};
			reg_manual_cmd:   prdata = {14'd0, man_a, man_ba, man_cmd};
			default:          prdata = 32'd0;
		endcase
	end

	// --------------------
	// registers
	// --------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ref_interval <= ref_interval_reset;
			man_req      <= 1'b0;
			ref_count    <= '0;
		end else begin
			if (access & pwrite & (paddr == reg_ref_interval)) begin
				ref_interval <= pwdata[15:0];
			end

			// held until the arbiter grants it
			if (man_setup) begin
				man_req <= 1'b1;
			end else if (man_gnt) begin
				man_req <= 1'b0;
			end

			if (ref_issued) begin
				ref_count <= ref_count + 16'd1;
			end
		end
	end

	// manual command fields, also read back
	always_ff @(posedge clk) begin
		if (man_setup) begin
			man_cmd <= ddr_cmd_e'(pwdata[2:0]);
			man_ba  <= pwdata[4:3];
			man_a   <= pwdata[17:5];
		end
	end

endmodule

`default_nettype wire

// File: source/ddr_refresh_timer.sv
`timescale 1ns/1ps
`default_nettype none

module ddr_refresh_timer (
	input  wire        clk,
	input  wire        reset,
	input  wire        initializing,
	input  wire [15:0] ref_interval,
	input  wire        ref_gnt,
	output logic       ref_req
);

	logic [15:0] count;

	// --------------------
	// interval counter
	// --------------------

	// counts down to zero, then raises the request
	// and sits still until the arbiter takes it
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count   <= '0;
			ref_req <= 1'b0;
		end else if (initializing) begin
			// keep loading so a new interval is seen at start
			count   <= ref_interval;
			ref_req <= 1'b0;
		end else if (ref_req) begin
			if (ref_gnt) begin
				ref_req <= 1'b0;
				count   <= ref_interval;
			end
		end else if (count == 16'd0) begin
			ref_req <= 1'b1;
		end else begin
			count <= count - 16'd1;
		end
	end

	// request holds, the count freezes while pending
	// reload takes the live register value, so a rewrite
	// of the interval applies from the next period on

endmodule

`default_nettype wire

// File: source/ddr_init_seq.sv
`timescale 1ns/1ps
`default_nettype none

module ddr_init_seq
	import ddr_pkg::*;
#(
	parameter logic [15:0] init_wait_cycles = 16'd20000,
	parameter logic [7:0]  step_cycles      = 8'd40,
	parameter int          ba_width         = 2,
	parameter int          a_width          = 13
) (
	input  wire                  clk,
	input  wire                  reset,
	output logic                 cke,
	output logic                 initializing,
	output logic                 init_valid,
	output ddr_cmd_e             init_cmd,
	output logic [ba_width-1:0]  init_ba,
	output logic [a_width-1:0]   init_a
);

	// state names the command issued last
	localparam logic [3:0] st_wait  = 4'd0;
	localparam logic [3:0] st_cke   = 4'd1;
	localparam logic [3:0] st_pall1 = 4'd2;
	localparam logic [3:0] st_emrs  = 4'd3;
	localparam logic [3:0] st_mrs1  = 4'd4;
	localparam logic [3:0] st_pall2 = 4'd5;
	localparam logic [3:0] st_ref1  = 4'd6;
	localparam logic [3:0] st_ref2  = 4'd7;
	localparam logic [3:0] st_mrs2  = 4'd8;

	// reload so that steps land step_cycles apart
	localparam logic [15:0] step_reload = {8'd0, step_cycles} - 16'd1;

	logic [3:0]          state;
	logic [15:0]         count;

	logic [3:0]          next_state;
	logic [15:0]         next_count;
	logic                next_initializing;
	logic                next_cke;
	logic                next_valid;
	ddr_cmd_e            next_cmd;
	logic [ba_width-1:0] next_ba;
	logic [a_width-1:0]  next_a;

	// everything holds once the sequence is over
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state        <= st_wait;
			count        <= init_wait_cycles;
			initializing <= 1'b1;
			cke          <= 1'b0;
			init_valid   <= 1'b0;
			init_cmd     <= cmd_nop;
			init_ba      <= '0;
			init_a       <= '0;
		end else if (initializing) begin
			state        <= next_state;
			count        <= next_count;
			initializing <= next_initializing;
			cke          <= next_cke;
			init_valid   <= next_valid;
			init_cmd     <= next_cmd;
			init_ba      <= next_ba;
			init_a       <= next_a;
		end
	end

	always_comb begin
		next_state        = state;
		next_count        = count - 16'd1;
		next_initializing = 1'b1;
		next_cke          = cke;
		next_valid        = 1'b0;
		next_cmd          = cmd_nop;
		next_ba           = '0;
		next_a            = '0;

		if (count == 16'd0) begin
			next_count = step_reload;
			case (state)
				st_wait: begin
					next_cke   = 1'b1;
					next_state = st_cke;
				end
				st_cke: begin
					next_valid = 1'b1;
					next_cmd   = cmd_pall;
					next_a[10] = 1'b1;
					next_state = st_pall1;
				end
				st_pall1: begin
					// extended mode register
					next_valid = 1'b1;
					next_cmd   = cmd_mrs;
					next_ba    = ba_width'(2'b01);
					next_a     = a_width'(emrs_init);
					next_state = st_emrs;
				end
				st_emrs: begin
					next_valid = 1'b1;
					next_cmd   = cmd_mrs;
					next_a     = a_width'(mrs_init_dll_reset);
					next_state = st_mrs1;
				end
				st_mrs1: begin
					next_valid = 1'b1;
					next_cmd   = cmd_pall;
					next_a[10] = 1'b1;
					next_state = st_pall2;
				end
				st_pall2: begin
					next_valid = 1'b1;
					next_cmd   = cmd_ref;
					next_state = st_ref1;
				end
				st_ref1: begin
					next_valid = 1'b1;
					next_cmd   = cmd_ref;
					next_state = st_ref2;
				end
				st_ref2: begin
					// DLL reset released
					next_valid = 1'b1;
					next_cmd   = cmd_mrs;
					next_a     = a_width'(mrs_init_normal);
					next_state = st_mrs2;
				end
				st_mrs2: begin
					next_initializing = 1'b0;
				end
				default: begin
					next_state = st_wait;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/ddr_pkg.sv
`default_nettype none

package ddr_pkg;

	// --------------------
	// abstract commands
	// --------------------

	// extended mode set is cmd_mrs sent to bank 01
	typedef enum logic [2:0] {
		cmd_nop  = 3'd0,
		cmd_pall = 3'd1,
		cmd_mrs  = 3'd2,
		cmd_ref  = 3'd3
	} ddr_cmd_e;

	// --------------------
	// mode register word
	// --------------------

	// same 13 address bits, read as MRS or as EMRS
	typedef union packed {
		struct packed {
			logic [3:0] reserved;
			logic       dll_reset;
			logic       test_mode;
			logic [2:0] cas_latency;
			logic       burst_type;
			logic [2:0] burst_len;
		} mrs;
		struct packed {
			logic [10:0] reserved;
			logic        drive_strength;
			logic        dll_disable;
		} emrs;
	} ddr_mode_word_u;

	// CL2, sequential, burst of two
	localparam ddr_mode_word_u mrs_init_dll_reset = 13'b0000_1_0_010_0_001;
	localparam ddr_mode_word_u mrs_init_normal    = 13'b0000_0_0_010_0_001;
	// normal drive, DLL on
	localparam ddr_mode_word_u emrs_init          = 13'b0;

	// --------------------
	// APB register offsets
	// --------------------
	localparam logic [7:0] reg_status       = 8'h00;
	localparam logic [7:0] reg_ref_interval = 8'h04;
	localparam logic [7:0] reg_manual_cmd   = 8'h08;

endpackage

`default_nettype wire
